/* verilog/ps2_pkg.sv */
package ps2_pkg;

   // consecutive equal samples before the filtered clock may change
   localparam int FILTER_LEN = 4;

   // host inhibit time before a transmit, in system clocks (scaled)
   localparam int INHIBIT_CYCLES = 64;
   localparam int INHIBIT_W = $clog2(INHIBIT_CYCLES);

   // start, 8 data, parity, stop
   localparam int FRAME_BITS = 11;

   typedef logic [7:0] ps2_byte_t;

   // host to device command
   localparam ps2_byte_t CMD_STREAM = 8'hf4; // enable data reporting

   // device response
   localparam ps2_byte_t ACK_BYTE = 8'hfa;

endpackage

/* verilog/mouse_pkg.sv */
package mouse_pkg;

   // visible area in pixels
   localparam int SCREEN_W = 640;
   localparam int SCREEN_H = 480;

   // report buffer
   localparam int FIFO_DEPTH = 4;
   localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

   // one decoded three-byte movement packet
   typedef struct packed {
      logic [2:0] btn;   // bit 0 left, bit 1 right, bit 2 middle
      logic       x_ovf;
      logic       y_ovf;
      logic [8:0] dx;    // two's complement
      logic [8:0] dy;    // two's complement, positive is up
   } mouse_report_t;

   // tracked pointer state
   typedef struct packed {
      logic [9:0] x;
      logic [8:0] y;
      logic [2:0] btn;
   } cursor_t;

endpackage

/* verilog/ps2_link.sv */
module ps2_link (
   input  logic               clk,
   input  logic               rst,
   input  logic               tx_start,
   input  ps2_pkg::ps2_byte_t cmd,
   inout  wire                ps2c,
   inout  wire                ps2d,
   output ps2_pkg::ps2_byte_t rx_byte,
   output logic               rx_valid,
   output logic               rx_err,
   output logic               tx_busy,
   output logic               tx_done
);
   import ps2_pkg::*;

   typedef enum logic [1:0] {
      st_idle,
      st_rx,
      st_inhibit,
      st_tx
   } state_t;

   state_t                  state;
   logic [1:0]              c_sync;
   logic [1:0]              d_sync;
   logic [FILTER_LEN-1:0]   c_hist;
   logic                    c_filt;
   logic                    c_filt_q;
   logic                    fall;
   logic [FRAME_BITS-1:0]   sr;      // rx frame or tx bits, lsb first
   logic [3:0]              bit_cnt;
   logic [INHIBIT_W-1:0]    inh_cnt;
   logic                    c_low;
   logic                    d_low;

   // open collector, only ever pull low
   assign ps2c = c_low ? 1'b0 : 1'bz;
   assign ps2d = d_low ? 1'b0 : 1'bz;

   // synchronise both lines, debounce the clock
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         c_sync   <= 2'b11;
         d_sync   <= 2'b11;
         c_hist   <= '1;
         c_filt   <= 1'b1;
         c_filt_q <= 1'b1;
      end
      else
      begin
         c_sync   <= {c_sync[0], ps2c};
         d_sync   <= {d_sync[0], ps2d};
         c_hist   <= {c_hist[FILTER_LEN-2:0], c_sync[1]};
         c_filt_q <= c_filt;
         if (&c_hist)
            c_filt <= 1'b1;
         else if (~|c_hist)
            c_filt <= 1'b0;
      end
   end

   assign fall = c_filt_q & ~c_filt;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state    <= st_idle;
         sr       <= '1;
         bit_cnt  <= '0;
         inh_cnt  <= '0;
         c_low    <= 1'b0;
         d_low    <= 1'b0;
         rx_valid <= 1'b0;
         tx_done  <= 1'b0;
      end
      else
      begin
         rx_valid <= 1'b0;
         tx_done  <= 1'b0;
         case (state)
            st_idle:
               if (tx_start)
               begin
                  // stop, odd parity, data; start bit comes from d_low
                  sr      <= {1'b1, 1'b1, ~^cmd, cmd};
                  inh_cnt <= '0;
                  c_low   <= 1'b1;
                  state   <= st_inhibit;
               end
               else if (fall)
               begin
                  sr      <= {d_sync[1], sr[FRAME_BITS-1:1]}; // start bit
                  bit_cnt <= 4'd1;
                  state   <= st_rx;
               end
            st_rx:
               if (fall)
               begin
                  sr      <= {d_sync[1], sr[FRAME_BITS-1:1]};
                  bit_cnt <= bit_cnt + 4'd1;
                  if (bit_cnt == 4'(FRAME_BITS - 1))
                  begin
                     rx_valid <= 1'b1;
                     state    <= st_idle;
                  end
               end
            st_inhibit:
            begin
               inh_cnt <= inh_cnt + 1'b1;
               if (inh_cnt == INHIBIT_W'(INHIBIT_CYCLES - 1))
               begin
                  c_low   <= 1'b0; // hand the clock back to the device
                  d_low   <= 1'b1; // request to send
                  bit_cnt <= '0;
                  state   <= st_tx;
               end
            end
            st_tx:
               if (fall)
               begin
                  bit_cnt <= bit_cnt + 4'd1;
                  if (bit_cnt == 4'(FRAME_BITS - 1))
                  begin
                     // device holds data low here as its ack
                     tx_done <= 1'b1;
                     state   <= st_idle;
                  end
                  else
                  begin
                     d_low <= ~sr[0]; // stop bit releases the line
                     sr    <= {1'b1, sr[FRAME_BITS-1:1]};
                  end
               end
            default:
               state <= st_idle;
         endcase
      end
   end

   assign tx_busy = (state != st_idle);
   assign rx_byte = sr[8:1];
   // start must be 0, stop 1, data plus parity odd
   assign rx_err  = sr[0] | ~sr[10] | ~(^sr[9:1]);

   a_rx_tx_excl: assert property (@(posedge clk) disable iff (rst)
      !(rx_valid && tx_done))
      else $error("rx_valid and tx_done high in the same cycle");

   a_start_idle: assert property (@(posedge clk) disable iff (rst)
      tx_start |-> !tx_busy)
      else $error("tx_start while link busy");

endmodule

/* verilog/mouse_ps2.sv */
module mouse_ps2 (
   input  logic                    clk,
   input  logic                    rst,
   input  ps2_pkg::ps2_byte_t      rx_byte,
   input  logic                    rx_valid,
   input  logic                    rx_err,
   input  logic                    tx_busy,
   input  logic                    tx_done,
   output logic                    tx_start,
   output ps2_pkg::ps2_byte_t      cmd,
   output mouse_pkg::mouse_report_t report,
   output logic                    report_valid,
   output logic                    init_done
);
   import ps2_pkg::*;
   import mouse_pkg::*;

   typedef enum logic [2:0] {
      st_send,
      st_wait_tx,
      st_wait_ack,
      st_pack1,
      st_pack2,
      st_pack3
   } state_t;

   state_t state;
   logic   rx_ok;

   assign cmd   = CMD_STREAM; // only command ever sent
   assign rx_ok = rx_valid && !rx_err;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state        <= st_send;
         tx_start     <= 1'b0;
         report_valid <= 1'b0;
         init_done    <= 1'b0;
      end
      else
      begin
         tx_start     <= 1'b0;
         report_valid <= 1'b0;
         case (state)
            st_send:
               if (!tx_busy)
               begin
                  tx_start <= 1'b1;
                  state    <= st_wait_tx;
               end
            st_wait_tx:
               if (tx_done)
                  state <= st_wait_ack;
            st_wait_ack:
               if (rx_valid)
               begin
                  if (rx_ok && rx_byte == ACK_BYTE)
                  begin
                     init_done <= 1'b1;
                     state     <= st_pack1;
                  end
                  else
                     state <= st_send; // try the command again
               end
            st_pack1:
               if (rx_ok && rx_byte[3]) // bit 3 is always set in byte 1
                  state <= st_pack2;
            st_pack2:
               if (rx_valid)
                  state <= rx_err ? st_pack1 : st_pack3;
            st_pack3:
               if (rx_valid)
               begin
                  report_valid <= !rx_err;
                  state        <= st_pack1;
               end
            default:
               state <= st_send;
         endcase
      end
   end

   // packet fields, loaded as the bytes arrive
   always_ff @(posedge clk)
   begin
      if (rx_ok)
      begin
         case (state)
            st_pack1:
            begin
               report.btn   <= rx_byte[2:0];
               report.dx[8] <= rx_byte[4];
               report.dy[8] <= rx_byte[5];
               report.x_ovf <= rx_byte[6];
               report.y_ovf <= rx_byte[7];
            end
            st_pack2:
               report.dx[7:0] <= rx_byte;
            st_pack3:
               report.dy[7:0] <= rx_byte;
            default:
               ;
         endcase
      end
   end

   a_report_after_init: assert property (@(posedge clk) disable iff (rst)
      report_valid |-> init_done)
      else $error("report before stream mode acknowledged");

endmodule

/* verilog/report_fifo.sv */
module report_fifo (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     push,
   input  mouse_pkg::mouse_report_t din,
   input  logic                     pop,
   output mouse_pkg::mouse_report_t head,
   output logic                     empty,
   output logic                     lost
);
   import mouse_pkg::*;

   mouse_report_t         mem [FIFO_DEPTH];
   logic [FIFO_PTR_W-1:0] rd_ptr;
   logic [FIFO_PTR_W-1:0] wr_ptr;
   logic [FIFO_PTR_W:0]   count;
   logic                  full;
   logic                  do_push;

   assign full    = (count == (FIFO_PTR_W + 1)'(FIFO_DEPTH));
   assign empty   = (count == '0);
   assign do_push = push && (!full || pop); // a pop frees the slot in time
   assign head    = mem[rd_ptr];            // first word falls through

   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[wr_ptr] <= din;
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
         lost   <= 1'b0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         if (do_push && !pop)
            count <= count + 1'b1;
         else if (pop && !do_push)
            count <= count - 1'b1;
         if (push && !do_push)
            lost <= 1'b1; // sticky until reset
      end
   end

   a_no_underflow: assert property (@(posedge clk) disable iff (rst)
      pop |-> !empty)
      else $error("pop from empty report fifo");

endmodule

/* verilog/cursor_tracker.sv */
module cursor_tracker (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     frame_tick,
   input  mouse_pkg::mouse_report_t head,
   input  logic                     empty,
   output logic                     pop,
   output mouse_pkg::cursor_t       cursor
);
   import mouse_pkg::*;

   logic signed [8:0]  dx;
   logic signed [8:0]  dy;
   logic signed [11:0] nx;
   logic signed [11:0] ny;
   logic [9:0]         x_clamp;
   logic [8:0]         y_clamp;

   assign pop = frame_tick && !empty; // one report per frame

   // overflowed axis does not move
   assign dx = head.x_ovf ? 9'sd0 : $signed(head.dx);
   assign dy = head.y_ovf ? 9'sd0 : $signed(head.dy);

   assign nx = $signed({2'b00, cursor.x}) + dx;
   assign ny = $signed({3'b000, cursor.y}) - dy; // screen y grows downward

   always_comb
   begin
      if (nx < 0)
         x_clamp = '0;
      else if (nx > SCREEN_W - 1)
         x_clamp = 10'(SCREEN_W - 1);
      else
         x_clamp = nx[9:0];

      if (ny < 0)
         y_clamp = '0;
      else if (ny > SCREEN_H - 1)
         y_clamp = 9'(SCREEN_H - 1);
      else
         y_clamp = ny[8:0];
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         cursor.x   <= 10'(SCREEN_W / 2); // screen centre
         cursor.y   <= 9'(SCREEN_H / 2);
         cursor.btn <= '0;
      end
      else if (pop)
      begin
         cursor.x   <= x_clamp;
         cursor.y   <= y_clamp;
         cursor.btn <= head.btn;
      end
   end

endmodule

/* verilog/mouse_subsystem.sv */
module mouse_subsystem (
   input  logic               clk,
   input  logic               rst,
   input  logic               frame_tick,
   inout  wire                ps2c,
   inout  wire                ps2d,
   output mouse_pkg::cursor_t cursor,
   output logic               init_done,
   output logic               lost
);
   import ps2_pkg::*;
   import mouse_pkg::*;

   ps2_byte_t     rx_byte;
   ps2_byte_t     cmd;
   logic          rx_valid;
   logic          rx_err;
   logic          tx_start;
   logic          tx_busy;
   logic          tx_done;
   mouse_report_t report;
   logic          report_valid;
   mouse_report_t head;
   logic          empty;
   logic          pop;

   ps2_link link_i (
      .clk      (clk),
      .rst      (rst),
      .tx_start (tx_start),
      .cmd      (cmd),
      .ps2c     (ps2c),
      .ps2d     (ps2d),
      .rx_byte  (rx_byte),
      .rx_valid (rx_valid),
      .rx_err   (rx_err),
      .tx_busy  (tx_busy),
      .tx_done  (tx_done)
   );

   mouse_ps2 engine_i (
      .clk          (clk),
      .rst          (rst),
      .rx_byte      (rx_byte),
      .rx_valid     (rx_valid),
      .rx_err       (rx_err),
      .tx_busy      (tx_busy),
      .tx_done      (tx_done),
      .tx_start     (tx_start),
      .cmd          (cmd),
      .report       (report),
      .report_valid (report_valid),
      .init_done    (init_done)
   );

   report_fifo fifo_i (
      .clk   (clk),
      .rst   (rst),
      .push  (report_valid),
      .din   (report),
      .pop   (pop),
      .head  (head),
      .empty (empty),
      .lost  (lost)
   );

   cursor_tracker tracker_i (
      .clk        (clk),
      .rst        (rst),
      .frame_tick (frame_tick),
      .head       (head),
      .empty      (empty),
      .pop        (pop),
      .cursor     (cursor)
   );

endmodule

/* dv/ps2_mouse_model.sv */
module ps2_mouse_model (
   input  logic       clk,
   inout  wire        ps2c,
   inout  wire        ps2d,
   input  logic       send_req,
   input  logic [7:0] send_data,
   input  logic       send_bad,
   output logic       busy,
   output int         cmd_count,
   output logic [7:0] last_cmd,
   output logic       cmd_ok,
   output int         faults
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam int         HALF          = 10;    // system clocks per half device clock
   localparam int         RELEASE_LIMIT = 1000;
   localparam logic [7:0] ACK           = 8'hfa; // acknowledge byte

   logic c_low;
   logic d_low;

   // open collector like the host side
   assign ps2c = c_low ? 1'b0 : 1'bz;
   assign ps2d = d_low ? 1'b0 : 1'bz;

   task automatic idle_clocks(input int n);
      repeat (n) @(posedge clk);
   endtask

   // device to host frame with data set up in the high phase
   task automatic send_frame(input logic [7:0] b, input logic bad);
      logic [10:0] bits;
      int          i;
      bits = {1'b1, (~^b) ^ bad, b, 1'b0}; // stop, parity, data, start
      for (i = 0; i < 11; i++)
      begin
         #2 d_low = ~bits[i];
         idle_clocks(HALF / 2);
         #2 c_low = 1'b1;
         idle_clocks(HALF);
         #2 c_low = 1'b0;
         idle_clocks(HALF / 2);
      end
      #2 d_low = 1'b0;
      idle_clocks(2 * HALF); // idle gap between frames
   endtask

   // host to device frame after the clock inhibit
   task automatic receive_command();
      logic [9:0] bits;
      int         n;
      int         i;
      n = 0;
      while (ps2c !== 1'b1 && n < RELEASE_LIMIT)
      begin
         @(posedge clk);
         n++;
      end
      if (ps2c !== 1'b1)
      begin
         $display("mouse model: host never released the clock line");
         faults++;
      end
      else if (ps2d !== 1'b0)
      begin
         $display("mouse model: no start bit after the clock inhibit");
         faults++;
      end
      else
      begin
         idle_clocks(HALF);
         for (i = 0; i < 10; i++)
         begin
            #2 c_low = 1'b1;
            idle_clocks(HALF);
            #2 c_low = 1'b0;
            idle_clocks(HALF / 2);
            bits[i] = ps2d; // host changed it while clock was low
            idle_clocks(HALF / 2);
         end
         // data held low over one more clock pulse as the ack bit
         #2 d_low = 1'b1;
         c_low = 1'b1;
         idle_clocks(HALF);
         #2 c_low = 1'b0;
         idle_clocks(HALF);
         #2 d_low = 1'b0;
         last_cmd = bits[7:0];
         cmd_ok   = (^bits[8:0]) && bits[9];
         cmd_count++;
         idle_clocks(2 * HALF);
         send_frame(ACK, 1'b0);
      end
   endtask

   initial
   begin
      c_low     = 1'b0;
      d_low     = 1'b0;
      busy      = 1'b0;
      cmd_count = 0;
      last_cmd  = 8'h00;
      cmd_ok    = 1'b0;
      faults    = 0;
      forever
      begin
         @(posedge clk);
         if (ps2c === 1'b0) // host inhibit means a command follows
         begin
            busy = 1'b1;
            receive_command();
            busy = 1'b0;
         end
         else if (send_req)
         begin
            busy = 1'b1;
            send_frame(send_data, send_bad);
            busy = 1'b0;
         end
      end
   end

endmodule

/* dv/tb_mouse_subsystem.sv */
module tb_mouse_subsystem;
   timeunit 1ns;
   timeprecision 100ps;
   import mouse_pkg::*;

   localparam int MAX_ROWS   = 16;
   localparam int MAX_BYTES  = 18;
   localparam int WAIT_LIMIT = 5000; // system clocks per wait
   localparam int X_MAX      = 639;  // 640 by 480 screen
   localparam int Y_MAX      = 479;
   localparam int Q_DEPTH    = 4;    // report fifo entries

   logic       clk;
   logic       rst;
   logic       frame_tick;
   wire        ps2c;
   wire        ps2d;
   cursor_t    cursor;
   logic       init_done;
   logic       lost;
   logic       send_req;
   logic [7:0] send_data;
   logic       send_bad;
   logic       model_busy;
   int         cmd_count;
   logic [7:0] last_cmd;
   logic       cmd_ok;
   int         model_faults;

   // stimulus table
   string      row_name  [MAX_ROWS];
   logic [7:0] row_bytes [MAX_ROWS][MAX_BYTES];
   int         row_len   [MAX_ROWS];
   int         row_bad   [MAX_ROWS]; // index of the byte sent with bad parity or -1
   int         row_ticks [MAX_ROWS];
   int         n_rows;

   // reference model
   int          ref_x;
   int          ref_y;
   logic [2:0]  ref_btn;
   logic        ref_lost;
   int          pk_state;  // packet bytes taken so far
   logic [15:0] pk_head;   // byte 1 and byte 2
   logic [23:0] ref_q [$]; // raw packets in the fifo

   int mismatches;
   int failures;
   int seed;
   bit run_ok;

   pullup (ps2c);
   pullup (ps2d);

   mouse_subsystem dut_i (
      .clk        (clk),
      .rst        (rst),
      .frame_tick (frame_tick),
      .ps2c       (ps2c),
      .ps2d       (ps2d),
      .cursor     (cursor),
      .init_done  (init_done),
      .lost       (lost)
   );

   ps2_mouse_model mouse_i (
      .clk       (clk),
      .ps2c      (ps2c),
      .ps2d      (ps2d),
      .send_req  (send_req),
      .send_data (send_data),
      .send_bad  (send_bad),
      .busy      (model_busy),
      .cmd_count (cmd_count),
      .last_cmd  (last_cmd),
      .cmd_ok    (cmd_ok),
      .faults    (model_faults)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic int signed9(input logic sign, input logic [7:0] low);
      return sign ? int'(low) - 256 : int'(low);
   endfunction

   function automatic int clamp(input int v, input int hi);
      return (v < 0) ? 0 : ((v > hi) ? hi : v);
   endfunction

   task automatic new_row(input string name, input int ticks);
      row_name[n_rows]  = name;
      row_len[n_rows]   = 0;
      row_bad[n_rows]   = -1;
      row_ticks[n_rows] = ticks;
      n_rows++;
   endtask

   task automatic add_byte(input logic [7:0] b);
      row_bytes[n_rows-1][row_len[n_rows-1]] = b;
      row_len[n_rows-1]++;
   endtask

   // next byte goes out with wrong parity
   task automatic mark_bad();
      row_bad[n_rows-1] = row_len[n_rows-1];
   endtask

   task automatic add_pkt(input logic [2:0] btn, input logic [8:0] dx, input logic [8:0] dy,
                          input logic xo, input logic yo);
      add_byte({yo, xo, dy[8], dx[8], 1'b1, btn});
      add_byte(dx[7:0]);
      add_byte(dy[7:0]);
   endtask

   task automatic build_table();
      int k;
      n_rows = 0;
      new_row("single_packet", 1);
      add_pkt(3'b001, 9'd10, 9'd5, 1'b0, 1'b0);
      new_row("clamp_right_top", 3);
      for (k = 0; k < 3; k++)
         add_pkt(3'b010, 9'd255, 9'd255, 1'b0, 1'b0);
      new_row("clamp_left_bottom", 3);
      for (k = 0; k < 3; k++)
         add_pkt(3'b100, 9'(-256), 9'(-256), 1'b0, 1'b0);
      new_row("x_overflow", 1);
      add_pkt(3'b000, 9'd100, 9'd50, 1'b1, 1'b0);
      new_row("y_overflow", 1);
      add_pkt(3'b011, 9'd60, 9'(-70), 1'b0, 1'b1);
      new_row("buffer_three", 3);
      add_pkt(3'b001, 9'd20, 9'(-30), 1'b0, 1'b0);
      add_pkt(3'b010, 9'(-5), 9'd40, 1'b0, 1'b0);
      add_pkt(3'b100, 9'd7, 9'd7, 1'b0, 1'b0);
      for (k = 0; k < 4; k++)
      begin
         new_row("random_packet", 1);
         add_pkt(3'($random(seed)), 9'($random(seed)), 9'($random(seed)), 1'b0, 1'b0);
      end
      new_row("resync_bit3", 1);
      add_byte(8'h01); // bit 3 clear so not a first byte
      add_pkt(3'b001, 9'd12, 9'd3, 1'b0, 1'b0);
      new_row("resync_parity", 2);
      add_byte(8'h09);
      mark_bad();
      add_byte(8'h33);
      add_byte(8'h44);
      add_pkt(3'b010, 9'(-9), 9'd15, 1'b0, 1'b0);
      new_row("fifo_overrun", 0);
      for (k = 0; k < 6; k++)
         add_pkt(3'(k), 9'(k * 11 - 30), 9'(20 - k * 7), 1'b0, 1'b0);
      new_row("fifo_drain", 5);
   endtask

   // engine and fifo rules applied to one byte as the mouse sends it
   task automatic ref_byte(input logic [7:0] b, input bit err);
      case (pk_state)
         0:
            if (!err && b[3])
            begin
               pk_head[15:8] = b;
               pk_state      = 1;
            end
         1:
            if (err)
               pk_state = 0;
            else
            begin
               pk_head[7:0] = b;
               pk_state     = 2;
            end
         default:
         begin
            if (!err && ref_q.size() < Q_DEPTH)
               ref_q.push_back({pk_head, b});
            else if (!err)
               ref_lost = 1'b1; // report dropped on a full fifo
            pk_state = 0;
         end
      endcase
   endtask

   task automatic ref_tick();
      logic [23:0] pkt;
      int          mx;
      int          my;
      if (ref_q.size() != 0)
      begin
         pkt     = ref_q.pop_front();
         mx      = pkt[22] ? 0 : signed9(pkt[20], pkt[15:8]);
         my      = pkt[23] ? 0 : signed9(pkt[21], pkt[7:0]);
         ref_x   = clamp(ref_x + mx, X_MAX);
         ref_y   = clamp(ref_y - my, Y_MAX); // y grows downward
         ref_btn = pkt[18:16];
      end
   endtask

   task automatic check_state(input string name);
      assert (int'(cursor.x) == ref_x)
      else
      begin
         $display("MISMATCH %s cursor x expected %0d actual %0d", name, ref_x, cursor.x);
         mismatches++;
      end
      assert (int'(cursor.y) == ref_y)
      else
      begin
         $display("MISMATCH %s cursor y expected %0d actual %0d", name, ref_y, cursor.y);
         mismatches++;
      end
      assert (cursor.btn == ref_btn)
      else
      begin
         $display("MISMATCH %s buttons expected %b actual %b", name, ref_btn, cursor.btn);
         mismatches++;
      end
      assert (lost == ref_lost)
      else
      begin
         $display("MISMATCH %s lost expected %b actual %b", name, ref_lost, lost);
         mismatches++;
      end
   endtask

   task automatic wait_init(output bit ok);
      int n;
      ok = 1'b0;
      for (n = 0; n < WAIT_LIMIT && !ok; n++)
      begin
         @(posedge clk);
         #2;
         ok = init_done;
      end
      if (!ok)
      begin
         $display("timeout: init_done never rose after reset");
         failures++;
      end
   endtask

   task automatic send_mouse_byte(input logic [7:0] b, input bit bad, output bit ok);
      int n;
      ok = 1'b0;
      for (n = 0; n < WAIT_LIMIT && model_busy; n++)
      begin
         @(posedge clk);
         #2;
      end
      if (model_busy)
      begin
         $display("timeout: mouse model stayed busy before byte %h", b);
         failures++;
         return;
      end
      send_data = b;
      send_bad  = bad;
      send_req  = 1'b1;
      @(posedge clk);
      #2 send_req = 1'b0;
      for (n = 0; n < WAIT_LIMIT && !ok; n++)
      begin
         @(posedge clk);
         #2;
         ok = !model_busy;
      end
      if (!ok)
      begin
         $display("timeout: mouse model never finished byte %h", b);
         failures++;
      end
   endtask

   task automatic give_tick();
      @(posedge clk);
      #2 frame_tick = 1'b1;
      @(posedge clk);
      #2 frame_tick = 1'b0;
   endtask

   task automatic run_rows(output bit ok);
      int r;
      int i;
      int t;
      wait_init(ok);
      if (!ok)
         return;
      assert (cmd_count == 1)
      else
      begin
         $display("MISMATCH init command count expected 1 actual %0d", cmd_count);
         mismatches++;
      end
      assert (last_cmd == 8'hf4)
      else
      begin
         $display("MISMATCH init command expected %h actual %h", 8'hf4, last_cmd);
         mismatches++;
      end
      assert (cmd_ok)
      else
      begin
         $display("host command frame arrived with a bad parity or stop bit");
         failures++;
      end
      check_state("init");
      for (r = 0; r < n_rows; r++)
      begin
         for (i = 0; i < row_len[r]; i++)
         begin
            send_mouse_byte(row_bytes[r][i], i == row_bad[r], ok);
            if (!ok)
               return;
            ref_byte(row_bytes[r][i], i == row_bad[r]);
         end
         if (row_ticks[r] == 0)
            check_state(row_name[r]);
         for (t = 0; t < row_ticks[r]; t++)
         begin
            give_tick();
            ref_tick();
            check_state(row_name[r]); // one report per tick
         end
      end
   endtask

   initial
   begin
      rst        = 1'b1;
      frame_tick = 1'b0;
      send_req   = 1'b0;
      send_data  = 8'h00;
      send_bad   = 1'b0;
      mismatches = 0;
      failures   = 0;
      seed       = 32'h639e;
      ref_x      = 320; // screen centre
      ref_y      = 240;
      ref_btn    = 3'b000;
      ref_lost   = 1'b0;
      pk_state   = 0;
      pk_head    = 16'h0000;
      build_table();
      repeat (10) @(posedge clk);
      #2 rst = 1'b0;
      run_rows(run_ok);
      $display("checks done: %0d mismatches, %0d other errors", mismatches,
               failures + model_faults);
      if (run_ok && mismatches == 0 && failures + model_faults == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

/* sim.f */
verilog/ps2_pkg.sv
verilog/mouse_pkg.sv
verilog/ps2_link.sv
verilog/mouse_ps2.sv
verilog/report_fifo.sv
verilog/cursor_tracker.sv
verilog/mouse_subsystem.sv
dv/ps2_mouse_model.sv
dv/tb_mouse_subsystem.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mouse_subsystem
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --timing --assert --timescale $(TIMESCALE)
PASS_MSG  ?= sim passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
